/* source/uartPkg.sv */
// shared UART constants and types for a fixed 8N1 format whose baud divisor is set here
`default_nettype none

package uartPkg;

	////////////////////////////////////////////////////////////////////////////
	// frame and timing
	////////////////////////////////////////////////////////////////////////////
	localparam int dataBits = 8;			// data bits per frame
	localparam int overSample = 16;			// ticks per bit
	localparam int clocksPerTick = 4;		// 64 clocks per bit
	localparam int stopTicks = 16;			// one stop bit

	// fifo geometry
	localparam int fifoDepth = 16;
	localparam int fifoAddrLen = 4;
	localparam int fifoCntLen = fifoAddrLen + 1;	// occupancy needs one extra bit

	// counter widths
	localparam int tickCntLen = $clog2(clocksPerTick);
	localparam int sampleCntLen = $clog2(overSample);
	localparam int bitCntLen = $clog2(dataBits);

	// terminal counts, sized to the counters they compare against
	localparam logic [tickCntLen-1:0] lastTickCnt = tickCntLen'(clocksPerTick - 1);
	localparam logic [sampleCntLen-1:0] midSample = sampleCntLen'(overSample / 2 - 1);
	localparam logic [sampleCntLen-1:0] lastSample = sampleCntLen'(overSample - 1);
	localparam logic [sampleCntLen-1:0] lastStopTick = sampleCntLen'(stopTicks - 1);
	localparam logic [bitCntLen-1:0] lastBit = bitCntLen'(dataBits - 1);
	localparam logic [fifoCntLen-1:0] fifoFullCnt = fifoCntLen'(fifoDepth);

	////////////////////////////////////////////////////////////////////////////
	// status byte bit positions
	////////////////////////////////////////////////////////////////////////////
	localparam int statRxEmpty = 0;
	localparam int statTxFull = 1;
	localparam int statTxBusy = 2;
	localparam int statFrameErr = 3;		// sticky, cleared by status read
	localparam int statOverrun = 4;			// sticky, cleared by status read

	// host commands, same order as the processor's UART instructions
	typedef enum logic [1:0] {
		opRead,
		opWrite,
		opStatus
	} hostOp_t;

	// serial engine phases, shared by receiver and transmitter
	typedef enum logic [1:0] {
		stIdle,
		stStart,
		stData,
		stStop
	} serState_t;

	// host handshake phases
	typedef enum logic [1:0] {
		hsWait,
		hsAck,
		hsRelease
	} hsState_t;

	typedef struct packed {
		logic [dataBits-1:0] data;
		logic frameErr;					// stop bit sampled low
	} rxEntry_t;

	typedef struct packed {
		hostOp_t op;
		logic [dataBits-1:0] wrData;
	} hostReq_t;

	typedef struct packed {
		logic [dataBits-1:0] rdData;
	} hostResp_t;

endpackage

`default_nettype wire

/* source/baudTickGen.sv */
// makes the 16x oversampling tick from a divisor that is fixed in the package
`timescale 1ns/10ps
`default_nettype none

module baudTickGen (
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	logic [uartPkg::tickCntLen-1:0] tickCnt;	// free running clock divider

	// count 0 .. clocksPerTick-1 and wrap
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tickCnt <= '0;
		end
		else if (tickCnt == uartPkg::lastTickCnt)
		begin
			tickCnt <= '0;
		end
		else
		begin
			tickCnt <= tickCnt + 1'b1;
		end
	end

	// one clock wide, shared by rx and tx
	assign sTick = (tickCnt == uartPkg::lastTickCnt);

endmodule

`default_nettype wire

/* source/uartRec.sv */
// receives 8N1 frames at 16x oversampling and flags a low stop bit but checks no parity
`timescale 1ns/10ps
`default_nettype none

module uartRec (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic rx,
	output logic rxDoneTick,
	output uartPkg::rxEntry_t rxEntry
);

	uartPkg::serState_t stateReg;
	logic [uartPkg::sampleCntLen-1:0] sReg;		// ticks within current bit
	logic [uartPkg::bitCntLen-1:0] nReg;		// data bit index
	logic [uartPkg::dataBits-1:0] bReg;			// shift register, LSB first
	logic rxMeta;
	logic rxSync;								// rx after two flops
	logic sampleData;
	logic stopEnd;

	// mid-bit of a data bit
	assign sampleData = sTick && (stateReg == uartPkg::stData) &&
		(sReg == uartPkg::lastSample);
	// end of stop window, also the stop bit sample point
	assign stopEnd = sTick && (stateReg == uartPkg::stStop) &&
		(sReg == uartPkg::lastStopTick);

	////////////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;		// idle line level
			rxSync <= 1'b1;
			stateReg <= uartPkg::stIdle;
			sReg <= '0;
			nReg <= '0;
			rxDoneTick <= 1'b0;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxDoneTick <= stopEnd;	// one clock after the closing tick
			case (stateReg)
				uartPkg::stIdle:
					if (!rxSync)
					begin
						stateReg <= uartPkg::stStart;	// falling edge seen
						sReg <= '0;
					end
				uartPkg::stStart:
					if (sTick)
					begin
						if (sReg == uartPkg::midSample)
						begin
							sReg <= '0;
							nReg <= '0;
							// line back high at mid start bit means a glitch
							if (rxSync)
								stateReg <= uartPkg::stIdle;
							else
								stateReg <= uartPkg::stData;
						end
						else
							sReg <= sReg + 1'b1;
					end
				uartPkg::stData:
					if (sTick)
					begin
						if (sReg == uartPkg::lastSample)
						begin
							sReg <= '0;
							if (nReg == uartPkg::lastBit)
								stateReg <= uartPkg::stStop;
							else
								nReg <= nReg + 1'b1;
						end
						else
							sReg <= sReg + 1'b1;
					end
				default:	// stop
					if (sTick)
					begin
						if (stopEnd)
							stateReg <= uartPkg::stIdle;
						else
							sReg <= sReg + 1'b1;
					end
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk)
	begin
		if (sampleData)
			bReg <= {rxSync, bReg[uartPkg::dataBits-1:1]};
		if (stopEnd)
		begin
			rxEntry.data <= bReg;
			rxEntry.frameErr <= !rxSync;	// low stop bit
		end
	end

	// a frame is reported only after its stop window and all eight data bits
	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> $past(stateReg == uartPkg::stStop) && (nReg == uartPkg::lastBit));

	// single cycle pulse
	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |=> !rxDoneTick);

endmodule

`default_nettype wire

/* source/uartTrans.sv */
// sends 8N1 frames LSB first with frames starting on a tick and one idle tick between them
`timescale 1ns/10ps
`default_nettype none

module uartTrans (
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic txEmpty,
	input  logic [uartPkg::dataBits-1:0] txData,
	output logic txTaken,
	output logic txBusy,
	output logic tx
);

	uartPkg::serState_t stateReg;
	logic [uartPkg::sampleCntLen-1:0] sReg;		// ticks within current bit
	logic [uartPkg::bitCntLen-1:0] nReg;		// data bit index
	logic [uartPkg::dataBits-1:0] shiftReg;		// bit 0 is next to go out
	logic dataBitEnd;

	// load only on a tick so every bit is a whole number of ticks
	assign txTaken = sTick && !txEmpty && (stateReg == uartPkg::stIdle);
	assign txBusy = (stateReg != uartPkg::stIdle);
	assign dataBitEnd = sTick && (stateReg == uartPkg::stData) &&
		(sReg == uartPkg::lastSample);

	////////////////////////////////////////////////////////////////////////////
	// control and line driver
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::stIdle;
			sReg <= '0;
			nReg <= '0;
			tx <= 1'b1;			// idle line
		end
		else
		begin
			case (stateReg)
				uartPkg::stIdle:
					if (txTaken)
					begin
						stateReg <= uartPkg::stStart;
						sReg <= '0;
						tx <= 1'b0;		// start bit
					end
				uartPkg::stStart:
					if (sTick)
					begin
						if (sReg == uartPkg::lastSample)
						begin
							stateReg <= uartPkg::stData;
							sReg <= '0;
							nReg <= '0;
							tx <= shiftReg[0];
						end
						else
							sReg <= sReg + 1'b1;
					end
				uartPkg::stData:
					if (sTick)
					begin
						if (sReg == uartPkg::lastSample)
						begin
							sReg <= '0;
							if (nReg == uartPkg::lastBit)
							begin
								stateReg <= uartPkg::stStop;
								tx <= 1'b1;		// stop bit
							end
							else
							begin
								nReg <= nReg + 1'b1;
								tx <= shiftReg[1];	// shiftReg moves on this edge too
							end
						end
						else
							sReg <= sReg + 1'b1;
					end
				default:	// stop
					if (sTick)
					begin
						if (sReg == uartPkg::lastStopTick)
							stateReg <= uartPkg::stIdle;
						else
							sReg <= sReg + 1'b1;
					end
			endcase
		end
	end

	// payload, latched from the fifo head as it is popped
	always_ff @(posedge clk)
	begin
		if (txTaken)
			shiftReg <= txData;
		else if (dataBitEnd)
			shiftReg <= shiftReg >> 1;
	end

	// line rests high whenever no frame is in flight
	assert property (@(posedge clk) disable iff (reset)
		!txBusy |-> tx);

endmodule

`default_nettype wire

/* source/syncFifo.sv */
// single clock FIFO whose push while full is dropped so the caller must watch full
`timescale 1ns/10ps
`default_nettype none

module syncFifo #(
	parameter type payload_t = logic [uartPkg::dataBits-1:0]
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic pop,
	input  payload_t pushData,
	output payload_t head,
	output logic full,
	output logic empty
);

	payload_t mem [uartPkg::fifoDepth];
	logic [uartPkg::fifoAddrLen-1:0] wrPtr;
	logic [uartPkg::fifoAddrLen-1:0] rdPtr;
	logic [uartPkg::fifoCntLen-1:0] count;		// occupancy
	logic doPush;
	logic doPop;

	assign doPush = push && !full;		// dropped when full
	assign doPop = pop && !empty;
	assign full = (count == uartPkg::fifoFullCnt);
	assign empty = (count == '0);
	assign head = mem[rdPtr];				// first-word fall-through

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// none, or both at once
			endcase
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// occupancy stays within depth and matches the pointer distance
	assert property (@(posedge clk) disable iff (reset)
		(count <= uartPkg::fifoFullCnt) &&
		(count[uartPkg::fifoAddrLen-1:0] == wrPtr - rdPtr));

	// consumers only pop what is there
	assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

endmodule

`default_nettype wire

/* source/uartHostPort.sv */
// four-phase req/ack command port that holds a write back while the tx FIFO is full
`timescale 1ns/10ps
`default_nettype none

module uartHostPort (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  uartPkg::hostReq_t hostReq,
	output logic ack,
	output uartPkg::hostResp_t hostResp,
	input  uartPkg::rxEntry_t rxHead,
	input  logic rxEmpty,
	input  logic rxFull,
	input  logic rxDoneTick,
	input  logic txFull,
	input  logic txBusy,
	output logic rxPop,
	output logic txPush,
	output logic [uartPkg::dataBits-1:0] txData
);

	uartPkg::hsState_t stateReg;
	logic [uartPkg::dataBits-1:0] statByte;
	logic frameErrFlag;		// sticky
	logic overrunFlag;		// sticky
	logic accept;			// command executes on this edge
	logic statRead;

	// a write stalls here until the tx fifo has room
	assign accept = req && (stateReg == uartPkg::hsWait) &&
		!((hostReq.op == uartPkg::opWrite) && txFull);
	assign rxPop = accept && (hostReq.op == uartPkg::opRead) && !rxEmpty;
	assign txPush = accept && (hostReq.op == uartPkg::opWrite);
	assign statRead = accept && (hostReq.op == uartPkg::opStatus);
	assign txData = hostReq.wrData;

	always_comb
	begin
		statByte = '0;		// unused bits read zero
		statByte[uartPkg::statRxEmpty] = rxEmpty;
		statByte[uartPkg::statTxFull] = txFull;
		statByte[uartPkg::statTxBusy] = txBusy;
		statByte[uartPkg::statFrameErr] = frameErrFlag;
		statByte[uartPkg::statOverrun] = overrunFlag;
	end

	////////////////////////////////////////////////////////////////////////////
	// handshake
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::hsWait;
			ack <= 1'b0;
		end
		else
		begin
			case (stateReg)
				uartPkg::hsWait:
					if (accept)
					begin
						ack <= 1'b1;
						stateReg <= uartPkg::hsAck;
					end
				uartPkg::hsAck:
					if (!req)
					begin
						ack <= 1'b0;	// host let go
						stateReg <= uartPkg::hsRelease;
					end
				default:
					stateReg <= uartPkg::hsWait;
			endcase
		end
	end

	// sticky errors, a new event beats the clear
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			frameErrFlag <= 1'b0;
			overrunFlag <= 1'b0;
		end
		else
		begin
			frameErrFlag <= (frameErrFlag && !statRead) || (rxPop && rxHead.frameErr);
			overrunFlag <= (overrunFlag && !statRead) || (rxDoneTick && rxFull);
		end
	end

	// response, held while ack is high
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			case (hostReq.op)
				uartPkg::opRead: hostResp.rdData <= rxEmpty ? '0 : rxHead.data;
				uartPkg::opStatus: hostResp.rdData <= statByte;
				default: hostResp.rdData <= '0;
			endcase
		end
	end

	// host holds the command steady for the whole handshake
	assert property (@(posedge clk) disable iff (reset)
		(req || ack) && $past(req || ack) |-> $stable(hostReq));

	// no second fifo access until the host ends the handshake
	assert property (@(posedge clk) disable iff (reset)
		(rxPop || txPush) |=> (!rxPop && !txPush) until !req);

endmodule

`default_nettype wire

/* source/uartPeripheral.sv */
// UART top level with fixed baud rate and 16 entry FIFOs in each direction
`timescale 1ns/10ps
`default_nettype none

module uartPeripheral (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  logic req,
	input  uartPkg::hostReq_t hostReq,
	output logic tx,
	output logic ack,
	output uartPkg::hostResp_t hostResp
);

	logic sTick;
	// receive side
	logic rxDoneTick;
	uartPkg::rxEntry_t rxEntry;
	uartPkg::rxEntry_t rxHead;
	logic rxPop;
	logic rxEmpty;
	logic rxFull;
	// transmit side
	logic txPush;
	logic txTaken;
	logic txEmpty;
	logic txFull;
	logic txBusy;
	logic [uartPkg::dataBits-1:0] txData;
	logic [uartPkg::dataBits-1:0] txHead;

	baudTickGen u_tickGen (.clk, .reset, .sTick);

	////////////////////////////////////////////////////////////////////////////
	// serial line to host
	////////////////////////////////////////////////////////////////////////////
	uartRec u_rec (.clk, .reset, .sTick, .rx, .rxDoneTick, .rxEntry);

	syncFifo #(.payload_t(uartPkg::rxEntry_t)) u_rxFifo (
		.clk, .reset,
		.push(rxDoneTick), .pop(rxPop),		// overrun when pushed full
		.pushData(rxEntry), .head(rxHead),
		.full(rxFull), .empty(rxEmpty)
	);

	// host to serial line
	syncFifo #(.payload_t(logic [uartPkg::dataBits-1:0])) u_txFifo (
		.clk, .reset,
		.push(txPush), .pop(txTaken),
		.pushData(txData), .head(txHead),
		.full(txFull), .empty(txEmpty)
	);

	uartTrans u_trans (
		.clk, .reset, .sTick, .txEmpty,
		.txData(txHead), .txTaken, .txBusy, .tx
	);

	uartHostPort u_hostPort (
		.clk, .reset, .req, .hostReq, .ack, .hostResp,
		.rxHead, .rxEmpty, .rxFull, .rxDoneTick,
		.txFull, .txBusy, .rxPop, .txPush, .txData
	);

endmodule

`default_nettype wire

/* tb/uartPeripheralTb.sv */
// directed testbench for the UART peripheral, relies on the fixed 64 clocks per bit from the package
`timescale 1ns/10ps
`default_nettype none

module uartPeripheralTb;

	localparam int bitClocks = uartPkg::overSample * uartPkg::clocksPerTick;	// 64
	localparam int badStopClocks = 40;		// low part of a bad stop bit, covers the sample
	localparam int timeoutCycles = 40000;	// ~43 frames of 640 clocks plus margin

	logic clk;
	logic reset;
	logic rx;
	logic req;
	logic tx;
	logic ack;
	uartPkg::hostReq_t hostReq;
	uartPkg::hostResp_t hostResp;
	integer seed = 64843;
	int cycleCount = 0;

	uartPeripheral u_dut (
		.clk, .reset, .rx, .req, .hostReq,
		.tx, .ack, .hostResp
	);

	always #10 clk = !clk;		// 20 ns period

	// run limit
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutCycles)
			stopOnFailure("timeout, the run did not finish within the cycle limit");
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic stopOnFailure(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkVal(input string testName, input logic [7:0] expected,
		input logic [7:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch in %s: expected %h, actual %h", testName, expected, actual);
			stopOnFailure("check failed");
		end
	endtask

	// status byte as the host should see it
	function automatic logic [7:0] expectStatus(input logic rxEmpty, input logic txFull,
		input logic txBusy, input logic frameErr, input logic overrun);
		logic [7:0] s;
		s = '0;
		s[uartPkg::statRxEmpty] = rxEmpty;
		s[uartPkg::statTxFull] = txFull;
		s[uartPkg::statTxBusy] = txBusy;
		s[uartPkg::statFrameErr] = frameErr;
		s[uartPkg::statOverrun] = overrun;
		return s;
	endfunction

	// one full four-phase handshake
	task automatic hostCmd(input uartPkg::hostOp_t op, input logic [7:0] wrData,
		output logic [7:0] rdData);
		@(posedge clk);
		hostReq.op <= op;
		hostReq.wrData <= wrData;
		req <= 1'b1;
		@(negedge clk);
		while (!ack)
			@(negedge clk);		// late ack on a full tx fifo
		rdData = hostResp.rdData;
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		while (ack)
			@(negedge clk);
	endtask

	// serial line model, host to DUT
	task automatic sendFrame(input logic [7:0] data, input logic badStop);
		integer i;
		@(posedge clk);
		rx <= 1'b0;		// start bit
		repeat (bitClocks) @(posedge clk);
		for (i = 0; i < 8; i++)
		begin
			rx <= data[i];		// LSB first
			repeat (bitClocks) @(posedge clk);
		end
		if (badStop)
		begin
			// low over the sample point, then high again before the false start matures
			rx <= 1'b0;
			repeat (badStopClocks) @(posedge clk);
			rx <= 1'b1;
			repeat (bitClocks - badStopClocks) @(posedge clk);
		end
		else
		begin
			rx <= 1'b1;
			repeat (bitClocks) @(posedge clk);
		end
	endtask

	// serial line model, DUT to host, samples at bit centres
	task automatic catchFrame(output logic [7:0] data, output logic stopBit);
		integer i;
		@(negedge tx);
		repeat (bitClocks / 2) @(negedge clk);
		if (tx !== 1'b0)
			stopOnFailure("start bit on tx did not last to its centre");
		for (i = 0; i < 8; i++)
		begin
			repeat (bitClocks) @(negedge clk);
			data[i] = tx;
		end
		repeat (bitClocks) @(negedge clk);
		stopBit = tx;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////
	task automatic testReset;
		logic [7:0] rd;
		@(negedge clk);
		checkVal("reset tx idle", 8'h01, {7'b0, tx});
		hostCmd(uartPkg::opStatus, 8'h00, rd);
		checkVal("reset status", expectStatus(1, 0, 0, 0, 0), rd);
		hostCmd(uartPkg::opRead, 8'h00, rd);
		checkVal("reset empty read", 8'h00, rd);
	endtask

	task automatic testTransmit;
		logic [7:0] sent [0:3];
		logic [7:0] rd;
		logic [7:0] got;
		logic stopBit;
		integer i;
		integer j;
		for (i = 0; i < 4; i++)
			sent[i] = $random(seed);
		fork
			begin
				for (i = 0; i < 4; i++)
					hostCmd(uartPkg::opWrite, sent[i], rd);	// back-to-back
				hostCmd(uartPkg::opStatus, 8'h00, rd);
				checkVal("transmit busy status", expectStatus(1, 0, 1, 0, 0), rd);
			end
			begin
				for (j = 0; j < 4; j++)
				begin
					catchFrame(got, stopBit);
					checkVal("transmit byte", sent[j], got);
					checkVal("transmit stop bit", 8'h01, {7'b0, stopBit});
				end
			end
		join
	endtask

	task automatic testReceive;
		logic [7:0] sent;
		logic [7:0] rd;
		integer i;
		for (i = 0; i < 3; i++)
		begin
			sent = $random(seed);
			sendFrame(sent, 1'b0);
			hostCmd(uartPkg::opRead, 8'h00, rd);
			checkVal("receive byte", sent, rd);
		end
		hostCmd(uartPkg::opStatus, 8'h00, rd);
		checkVal("receive drained status", expectStatus(1, 0, 0, 0, 0), rd);
	endtask

	task automatic testFraming;
		logic [7:0] sent;
		logic [7:0] rd;
		sent = $random(seed);
		sendFrame(sent, 1'b1);
		hostCmd(uartPkg::opRead, 8'h00, rd);
		checkVal("framing byte", sent, rd);
		hostCmd(uartPkg::opStatus, 8'h00, rd);
		checkVal("framing error status", expectStatus(1, 0, 0, 1, 0), rd);
		hostCmd(uartPkg::opStatus, 8'h00, rd);
		checkVal("framing error cleared", expectStatus(1, 0, 0, 0, 0), rd);
	endtask

	task automatic testOverrun;
		logic [7:0] sent [0:16];
		logic [7:0] rd;
		integer i;
		for (i = 0; i < 17; i++)
		begin
			sent[i] = $random(seed);
			sendFrame(sent[i], 1'b0);	// no reads, 17th byte is lost
		end
		hostCmd(uartPkg::opStatus, 8'h00, rd);
		checkVal("overrun status", expectStatus(0, 0, 0, 0, 1), rd);
		for (i = 0; i < 16; i++)
		begin
			hostCmd(uartPkg::opRead, 8'h00, rd);
			checkVal("overrun kept byte", sent[i], rd);
		end
		hostCmd(uartPkg::opStatus, 8'h00, rd);
		checkVal("overrun cleared", expectStatus(1, 0, 0, 0, 0), rd);
	endtask

	task automatic testBackPressure;
		logic [7:0] sent [0:17];
		logic [7:0] rd;
		logic [7:0] got;
		logic stopBit;
		integer i;
		integer j;
		for (i = 0; i < 18; i++)
			sent[i] = $random(seed);
		fork
			for (i = 0; i < 18; i++)
				hostCmd(uartPkg::opWrite, sent[i], rd);	// stalls once the fifo fills
			for (j = 0; j < 18; j++)
			begin
				catchFrame(got, stopBit);
				checkVal("back-pressure byte", sent[j], got);
				checkVal("back-pressure stop bit", 8'h01, {7'b0, stopBit});
			end
		join
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		rx = 1'b1;			// idle line
		req = 1'b0;
		hostReq = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		testReset();
		testTransmit();
		testReceive();
		testFraming();
		testOverrun();
		testBackPressure();
		repeat (4) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* uartPeripheral.f */
source/uartPkg.sv
source/baudTickGen.sv
source/uartRec.sv
source/uartTrans.sv
source/syncFifo.sv
source/uartHostPort.sv
source/uartPeripheral.sv
tb/uartPeripheralTb.sv
